/* axi_iso_macros.svh */
// AXI isolation parameter macros
`ifndef AXI_ISO_MACROS_SVH
`define AXI_ISO_MACROS_SVH

// Limit on bursts accepted downstream whose last beat has not yet come back
// The tracker stops accepting requests once the owed count reaches this value
`define AXI_ISO_MAX_OUTSTANDING 8

// Width of the AXI transaction ID carried on both AR and R
`define AXI_ISO_ID_W 4

// Width of the read address
`define AXI_ISO_ADDR_W 32

// Width of one read data beat
`define AXI_ISO_DATA_W 32

// Width of the burst length field, in AXI encoding (beats minus one)
`define AXI_ISO_LEN_W 8

`endif

/* axi_iso_axi_pkg.sv */
// AXI read channel types
`include "axi_iso_macros.svh"

package axi_iso_axi_pkg;

  // Field types for the read channels
  // Each one takes its width from the shared macros
  typedef logic [`AXI_ISO_ID_W-1:0]   axi_id_t;
  typedef logic [`AXI_ISO_ADDR_W-1:0] axi_addr_t;
  typedef logic [`AXI_ISO_DATA_W-1:0] axi_data_t;
  typedef logic [`AXI_ISO_LEN_W-1:0]  axi_len_t;

  // Read response code as defined by AXI
  // OKAY, EXOKAY, SLVERR and DECERR all fit in two bits
  typedef logic [1:0] axi_resp_t;

  // Read request payload as it travels on the AR path
  // The valid and ready handshake bits are kept outside the struct
  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
  } ar_payload_t;

  // Read response payload as it travels on the R path
  // The last flag marks the final beat of a burst and drives the owed count
  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } r_payload_t;

endpackage

/* axi_iso_ctrl_pkg.sv */
// AXI isolation control types
`include "axi_iso_macros.svh"

package axi_iso_ctrl_pkg;

  // States of the isolation FSM
  // ISO_OPEN passes traffic, ISO_BLOCKED holds while the request is high
  // ISO_DRAIN waits for owed last beats after the request has dropped
  typedef enum logic [1:0] {
    ISO_OPEN,
    ISO_BLOCKED,
    ISO_DRAIN
  } iso_state_e;

  // Owed burst count, wide enough to hold zero through the limit itself
  typedef logic [$clog2(`AXI_ISO_MAX_OUTSTANDING + 1)-1:0] out_count_t;

endpackage

/* axi_iso_skid.sv */
// Two-entry skid stage
`timescale 1ns/1ns

module axi_iso_skid #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  // Main entry drives the output
  // Spare entry catches the item that arrives while the main entry is stalled
  logic [WIDTH-1:0] main_q;
  logic             main_valid_q;
  logic [WIDTH-1:0] spare_q;
  logic             spare_valid_q;

  logic in_fire;
  logic main_load;
  logic spare_load;

  // The sender only sees a flop, so ready never depends on out_ready
  // in the same cycle
  assign in_ready = ~spare_valid_q;

  assign out_valid = main_valid_q;
  assign out_data  = main_q;

  assign in_fire = in_valid & in_ready;

  // Main entry can take a new item when it is empty or is leaving now
  assign main_load = ~main_valid_q | out_ready;

  // An item goes to the spare only when main is full and stays full
  assign spare_load = in_fire & main_valid_q & ~out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      main_valid_q  <= 1'b0;
      spare_valid_q <= 1'b0;
    end else begin
      // A waiting spare item always has priority over new input to keep order
      if (main_load) begin
        main_valid_q <= spare_valid_q | in_fire;
      end
      if (spare_valid_q) begin
        // Spare empties as soon as main drains, since it moves into main
        spare_valid_q <= ~out_ready;
      end else begin
        spare_valid_q <= spare_load;
      end
    end
  end

  // Payload of both entries moves on the same load enables as the valids
  always_ff @(posedge clk) begin
    if (main_load) begin
      main_q <= spare_valid_q ? spare_q : in_data;
    end
    if (spare_load) begin
      spare_q <= in_data;
    end
  end

endmodule

/* axi_iso_req_tracker.sv */
// AXI read isolation tracker
`timescale 1ns/1ns
`include "axi_iso_macros.svh"

module axi_iso_req_tracker (
  input  logic                        clk,
  input  logic                        rst,
  // AR channel from the upstream manager
  input  logic                        up_ar_valid,
  output logic                        up_ar_ready,
  input  axi_iso_axi_pkg::ar_payload_t up_ar,
  // AR channel towards the downstream subordinate
  output logic                        dn_ar_valid,
  input  logic                        dn_ar_ready,
  output axi_iso_axi_pkg::ar_payload_t dn_ar,
  // R channel from the downstream subordinate
  input  logic                        dn_r_valid,
  output logic                        dn_r_ready,
  input  axi_iso_axi_pkg::r_payload_t  dn_r,
  // R channel back to the upstream manager
  output logic                        up_r_valid,
  input  logic                        up_r_ready,
  output axi_iso_axi_pkg::r_payload_t  up_r,
  // Isolation handshake, both plain levels
  input  logic                        isolate_req,
  output logic                        isolate_done
);

  localparam axi_iso_ctrl_pkg::out_count_t MAX_COUNT =
    axi_iso_ctrl_pkg::out_count_t'(`AXI_ISO_MAX_OUTSTANDING);

  axi_iso_ctrl_pkg::out_count_t count_q;
  axi_iso_ctrl_pkg::iso_state_e state_q;
  axi_iso_ctrl_pkg::iso_state_e state_d;

  logic isolated;
  logic at_limit;
  logic count_zero;
  logic incr;
  logic decr;

  // Blocking starts in the same cycle as the request and lasts until the
  // FSM is back in the open state
  assign isolated = isolate_req | (state_q != axi_iso_ctrl_pkg::ISO_OPEN);

  assign at_limit   = (count_q == MAX_COUNT);
  assign count_zero = (count_q == '0);

  // Requests pass only when open and below the limit
  assign dn_ar_valid = up_ar_valid & ~isolated & ~at_limit;
  assign up_ar_ready = dn_ar_ready & ~isolated & ~at_limit;
  assign dn_ar       = up_ar;

  // While isolated, responses are swallowed here and never reach upstream
  assign up_r_valid = dn_r_valid & ~isolated;
  assign dn_r_ready = up_r_ready | isolated;
  assign up_r       = dn_r;

  // One burst becomes owed per request sent downstream
  assign incr = dn_ar_valid & dn_ar_ready;

  // Last beats settle a burst whether forwarded or discarded
  assign decr = dn_r_valid & dn_r_ready & dn_r.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (incr & ~decr) begin
      count_q <= count_q + axi_iso_ctrl_pkg::out_count_t'(1);
    end else if (decr & ~incr) begin
      count_q <= count_q - axi_iso_ctrl_pkg::out_count_t'(1);
    end
  end

  // Isolation FSM
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      axi_iso_ctrl_pkg::ISO_OPEN: begin
        if (isolate_req) begin
          state_d = axi_iso_ctrl_pkg::ISO_BLOCKED;
        end
      end
      axi_iso_ctrl_pkg::ISO_BLOCKED: begin
        // Once the request drops, leave directly if nothing is owed
        if (!isolate_req) begin
          state_d = count_zero ? axi_iso_ctrl_pkg::ISO_OPEN : axi_iso_ctrl_pkg::ISO_DRAIN;
        end
      end
      axi_iso_ctrl_pkg::ISO_DRAIN: begin
        if (isolate_req) begin
          state_d = axi_iso_ctrl_pkg::ISO_BLOCKED;
        end else if (count_zero) begin
          state_d = axi_iso_ctrl_pkg::ISO_OPEN;
        end
      end
      default: begin
        state_d = axi_iso_ctrl_pkg::ISO_OPEN;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= axi_iso_ctrl_pkg::ISO_OPEN;
    end else begin
      state_q <= state_d;
    end
  end

  // Done comes straight from the state flops, so it is registered
  assign isolate_done = (state_q != axi_iso_ctrl_pkg::ISO_OPEN);

endmodule

/* axi_iso_top.sv */
// AXI read isolation top level
`timescale 1ns/1ns

module axi_iso_top (
  input  logic                         clk,
  input  logic                         rst,
  // Upstream manager side
  input  logic                         up_ar_valid,
  output logic                         up_ar_ready,
  input  axi_iso_axi_pkg::ar_payload_t up_ar,
  output logic                         up_r_valid,
  input  logic                         up_r_ready,
  output axi_iso_axi_pkg::r_payload_t  up_r,
  // Downstream subordinate side
  output logic                         dn_ar_valid,
  input  logic                         dn_ar_ready,
  output axi_iso_axi_pkg::ar_payload_t dn_ar,
  input  logic                         dn_r_valid,
  output logic                         dn_r_ready,
  input  axi_iso_axi_pkg::r_payload_t  dn_r,
  // Isolation levels
  input  logic                         isolate_req,
  output logic                         isolate_done
);

  localparam int AR_W = $bits(axi_iso_axi_pkg::ar_payload_t);
  localparam int R_W  = $bits(axi_iso_axi_pkg::r_payload_t);

  // Hop between the tracker and the AR skid stage
  logic                         trk_ar_valid;
  logic                         trk_ar_ready;
  axi_iso_axi_pkg::ar_payload_t trk_ar;

  // Hop between the R skid stage and the tracker
  logic                         skid_r_valid;
  logic                         skid_r_ready;
  axi_iso_axi_pkg::r_payload_t  skid_r;

  // Tracker sits next to the upstream port on both paths
  axi_iso_req_tracker u_tracker (
    .clk          (clk),
    .rst          (rst),
    .up_ar_valid  (up_ar_valid),
    .up_ar_ready  (up_ar_ready),
    .up_ar        (up_ar),
    .dn_ar_valid  (trk_ar_valid),
    .dn_ar_ready  (trk_ar_ready),
    .dn_ar        (trk_ar),
    .dn_r_valid   (skid_r_valid),
    .dn_r_ready   (skid_r_ready),
    .dn_r         (skid_r),
    .up_r_valid   (up_r_valid),
    .up_r_ready   (up_r_ready),
    .up_r         (up_r),
    .isolate_req  (isolate_req),
    .isolate_done (isolate_done)
  );

  // Request register stage towards the subordinate
  axi_iso_skid #(
    .WIDTH (AR_W)
  ) u_ar_skid (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (trk_ar_valid),
    .in_ready  (trk_ar_ready),
    .in_data   (trk_ar),
    .out_valid (dn_ar_valid),
    .out_ready (dn_ar_ready),
    .out_data  (dn_ar)
  );

  // Response register stage from the subordinate
  axi_iso_skid #(
    .WIDTH (R_W)
  ) u_r_skid (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (dn_r_valid),
    .in_ready  (dn_r_ready),
    .in_data   (dn_r),
    .out_valid (skid_r_valid),
    .out_ready (skid_r_ready),
    .out_data  (skid_r)
  );

endmodule

/* axi_iso_props.sv */
// AXI isolation tracker assertions
`timescale 1ns/1ns
`include "axi_iso_macros.svh"

module axi_iso_props (
  input logic                         clk,
  input logic                         rst,
  input logic                         isolate_req,
  input logic                         isolate_done,
  input axi_iso_ctrl_pkg::out_count_t count,
  input logic                         ar_valid,
  input logic                         ar_ready,
  input axi_iso_axi_pkg::ar_payload_t ar
);

  // A new isolation request only starts while the FSM is open
  a_req_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(isolate_req) |-> !isolate_done)
    else $error("isolate_req rose while isolate_done was high");

  // The request is only withdrawn after isolation was reported
  a_req_fall: assert property (@(posedge clk) disable iff (rst)
    $fell(isolate_req) |-> isolate_done)
    else $error("isolate_req fell while isolate_done was low");

  a_count_limit: assert property (@(posedge clk) disable iff (rst)
    count <= axi_iso_ctrl_pkg::out_count_t'(`AXI_ISO_MAX_OUTSTANDING))
    else $error("owed count went past the outstanding limit");

  // A request offered downstream stays put until it is taken
  a_ar_stable: assert property (@(posedge clk) disable iff (rst)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else $error("downstream AR valid or payload changed before ready");

endmodule

bind axi_iso_req_tracker axi_iso_props u_props (
  .clk          (clk),
  .rst          (rst),
  .isolate_req  (isolate_req),
  .isolate_done (isolate_done),
  .count        (count_q),
  .ar_valid     (dn_ar_valid),
  .ar_ready     (dn_ar_ready),
  .ar           (dn_ar)
);

/* axi_iso_tb.sv */
// AXI read isolation testbench
`timescale 1ns/1ns
`include "axi_iso_macros.svh"

module axi_iso_tb;

  // Cycle budget of each test
  // The watchdog allows twice their sum
  localparam int RESET_CYCLES = 4;
  localparam int PASS_CYCLES  = 30;
  localparam int BP_CYCLES    = 90;
  localparam int LIMIT_CYCLES = 60;
  localparam int ISO_CYCLES   = 40;
  localparam int DRAIN_CYCLES = 50;
  localparam int BUDGET = RESET_CYCLES + PASS_CYCLES + BP_CYCLES + LIMIT_CYCLES +
                          ISO_CYCLES + DRAIN_CYCLES;
  localparam int STREAM_MAX = 64;

  logic                         clk;
  logic                         rst;
  logic                         up_ar_valid;
  logic                         up_ar_ready;
  axi_iso_axi_pkg::ar_payload_t up_ar;
  logic                         up_r_valid;
  logic                         up_r_ready;
  axi_iso_axi_pkg::r_payload_t  up_r;
  logic                         dn_ar_valid;
  logic                         dn_ar_ready;
  axi_iso_axi_pkg::ar_payload_t dn_ar;
  logic                         dn_r_valid;
  logic                         dn_r_ready;
  axi_iso_axi_pkg::r_payload_t  dn_r;
  logic                         isolate_req;
  logic                         isolate_done;

  int seed;
  int mismatches;
  int failures;

  axi_iso_top i_dut (
    .clk          (clk),
    .rst          (rst),
    .up_ar_valid  (up_ar_valid),
    .up_ar_ready  (up_ar_ready),
    .up_ar        (up_ar),
    .up_r_valid   (up_r_valid),
    .up_r_ready   (up_r_ready),
    .up_r         (up_r),
    .dn_ar_valid  (dn_ar_valid),
    .dn_ar_ready  (dn_ar_ready),
    .dn_ar        (dn_ar),
    .dn_r_valid   (dn_r_valid),
    .dn_r_ready   (dn_r_ready),
    .dn_r         (dn_r),
    .isolate_req  (isolate_req),
    .isolate_done (isolate_done)
  );

  always #4 clk = ~clk;

  function automatic logic rand_bit();
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[0];
  endfunction

  function automatic axi_iso_axi_pkg::ar_payload_t rand_ar();
    axi_iso_axi_pkg::ar_payload_t p;
    logic [31:0] rnd;
    rnd    = $random(seed);
    p.id   = rnd[`AXI_ISO_ID_W-1:0];
    p.len  = rnd[`AXI_ISO_ID_W +: `AXI_ISO_LEN_W];
    p.addr = $random(seed);
    return p;
  endfunction

  function automatic axi_iso_axi_pkg::r_payload_t rand_r(input logic last);
    axi_iso_axi_pkg::r_payload_t p;
    logic [31:0] rnd;
    rnd    = $random(seed);
    p.id   = rnd[`AXI_ISO_ID_W-1:0];
    p.resp = rnd[`AXI_ISO_ID_W +: 2];
    p.data = $random(seed);
    p.last = last;
    return p;
  endfunction

  task automatic note_failure(input string what);
    $display("error: %s", what);
    failures++;
  endtask

  task automatic check_ar(input string name, input axi_iso_axi_pkg::ar_payload_t got, exp);
    if (got !== exp) begin
      $display("mismatch: %s got 0x%0h expected 0x%0h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_r(input string name, input axi_iso_axi_pkg::r_payload_t got, exp);
    if (got !== exp) begin
      $display("mismatch: %s got 0x%0h expected 0x%0h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("mismatch: %s got 0x%0h expected 0x%0h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_count(input string name, input axi_iso_ctrl_pkg::out_count_t got, exp);
    if (got !== exp) begin
      $display("mismatch: %s got 0x%0h expected 0x%0h", name, got, exp);
      mismatches++;
    end
  endtask

  // Owed count settles on the edge after the last handshake of a stream
  task automatic verify_owed(input int n);
    @(negedge clk);
    #1;
    check_count("count_q", i_dut.u_tracker.count_q, axi_iso_ctrl_pkg::out_count_t'(n));
  endtask

  // Sends n requests upstream and checks them in order at the downstream port
  task automatic stream_ar(input int n, input bit bp);
    axi_iso_axi_pkg::ar_payload_t exp_q[$];
    axi_iso_axi_pkg::ar_payload_t cur;
    int   sent;
    int   got;
    int   cyc;
    logic acc_prev;
    sent     = 0;
    got      = 0;
    cyc      = 0;
    acc_prev = 1'b0;
    cur      = rand_ar();
    while (got < n && cyc < STREAM_MAX) begin
      @(negedge clk);
      up_ar_valid = (sent < n);
      up_ar       = cur;
      dn_ar_ready = bp ? rand_bit() : 1'b1;
      #1;
      // Without back-pressure an accepted request shows up one cycle later
      if (!bp && acc_prev)
        check_bit("dn_ar_valid", dn_ar_valid, 1'b1);
      acc_prev = up_ar_valid & up_ar_ready;
      if (acc_prev) begin
        exp_q.push_back(cur);
        sent++;
        cur = rand_ar();
      end
      if (dn_ar_valid & dn_ar_ready) begin
        if (exp_q.size() == 0)
          note_failure("a request reached downstream that was never sent");
        else
          check_ar("dn_ar", dn_ar, exp_q.pop_front());
        got++;
      end
      cyc++;
    end
    if (got < n)
      note_failure("not every request reached the downstream port");
  endtask

  // Returns n response beats with a last beat closing every burst of the given length
  task automatic stream_r(input int n, input int burst, input bit bp);
    axi_iso_axi_pkg::r_payload_t exp_q[$];
    axi_iso_axi_pkg::r_payload_t cur;
    int   sent;
    int   got;
    int   cyc;
    logic acc_prev;
    sent     = 0;
    got      = 0;
    cyc      = 0;
    acc_prev = 1'b0;
    cur      = rand_r(burst == 1);
    while (got < n && cyc < STREAM_MAX) begin
      @(negedge clk);
      dn_r_valid = (sent < n);
      dn_r       = cur;
      up_r_ready = bp ? rand_bit() : 1'b1;
      #1;
      if (!bp && acc_prev)
        check_bit("up_r_valid", up_r_valid, 1'b1);
      acc_prev = dn_r_valid & dn_r_ready;
      if (acc_prev) begin
        exp_q.push_back(cur);
        sent++;
        cur = rand_r((sent % burst) == burst - 1);
      end
      if (up_r_valid & up_r_ready) begin
        if (exp_q.size() == 0)
          note_failure("a response reached upstream that was never sent");
        else
          check_r("up_r", up_r, exp_q.pop_front());
        got++;
      end
      cyc++;
    end
    if (got < n)
      note_failure("not every response reached the upstream port");
  endtask

  // Offers a request that must stay blocked for the given number of cycles
  task automatic hold_blocked(input int cycles);
    @(negedge clk);
    up_ar_valid = 1'b1;
    up_ar       = rand_ar();
    dn_ar_ready = 1'b1;
    repeat (cycles) begin
      #1;
      check_bit("up_ar_ready", up_ar_ready, 1'b0);
      check_bit("dn_ar_valid", dn_ar_valid, 1'b0);
      @(negedge clk);
    end
    up_ar_valid = 1'b0;
  endtask

  // Returns n last beats while isolated and checks that none shows up upstream
  task automatic discard_r(input int n);
    axi_iso_axi_pkg::r_payload_t cur;
    int sent;
    int cyc;
    sent = 0;
    cyc  = 0;
    cur  = rand_r(1'b1);
    while (sent < n && cyc < STREAM_MAX) begin
      @(negedge clk);
      dn_r_valid = 1'b1;
      dn_r       = cur;
      up_r_ready = 1'b0;
      #1;
      check_bit("up_r_valid", up_r_valid, 1'b0);
      // The tracker drains the R skid stage, so it never fills up
      check_bit("dn_r_ready", dn_r_ready, 1'b1);
      if (dn_r_ready) begin
        sent++;
        cur = rand_r(1'b1);
      end
      cyc++;
    end
    if (sent < n)
      note_failure("responses were not absorbed while isolated");
    // Let the R skid stage empty into the tracker
    repeat (3) begin
      @(negedge clk);
      dn_r_valid = 1'b0;
      #1;
      check_bit("up_r_valid", up_r_valid, 1'b0);
    end
  endtask

  task automatic pass_through();
    stream_ar(4, 1'b0);
    verify_owed(4);
    stream_r(8, 2, 1'b0);
    verify_owed(0);
  endtask

  task automatic back_pressure();
    stream_ar(6, 1'b1);
    verify_owed(6);
    stream_r(12, 2, 1'b1);
    verify_owed(0);
  endtask

  task automatic outstanding_limit();
    stream_ar(`AXI_ISO_MAX_OUTSTANDING, 1'b0);
    verify_owed(`AXI_ISO_MAX_OUTSTANDING);
    hold_blocked(3);
    // One returned last beat frees exactly one slot
    stream_r(1, 1, 1'b0);
    stream_ar(1, 1'b0);
    hold_blocked(3);
    stream_r(`AXI_ISO_MAX_OUTSTANDING, 1, 1'b0);
    verify_owed(0);
  endtask

  task automatic isolation();
    stream_ar(3, 1'b0);
    @(negedge clk);
    isolate_req = 1'b1;
    #1;
    // Blocking is combinational and done follows one cycle later
    check_bit("up_ar_ready", up_ar_ready, 1'b0);
    check_bit("isolate_done", isolate_done, 1'b0);
    @(negedge clk);
    #1;
    check_bit("isolate_done", isolate_done, 1'b1);
    hold_blocked(4);
    discard_r(1);
    verify_owed(2);
  endtask

  task automatic release_and_drain();
    int cyc;
    @(negedge clk);
    isolate_req = 1'b0;
    // Two bursts are still owed, so done has to stay up
    repeat (3) begin
      @(negedge clk);
      #1;
      check_bit("isolate_done", isolate_done, 1'b1);
    end
    discard_r(1);
    // One burst is still owed after the first return
    check_bit("isolate_done", isolate_done, 1'b1);
    discard_r(1);
    cyc = 0;
    while (isolate_done && cyc < STREAM_MAX) begin
      @(negedge clk);
      #1;
      cyc++;
    end
    if (isolate_done)
      note_failure("isolate_done stayed high after every owed burst came back");
    verify_owed(0);
    stream_ar(1, 1'b0);
    stream_r(1, 1, 1'b0);
    verify_owed(0);
  endtask

  initial begin
    seed        = 72;
    mismatches  = 0;
    failures    = 0;
    clk         = 1'b0;
    rst         = 1'b1;
    up_ar_valid = 1'b0;
    up_ar       = '0;
    dn_ar_ready = 1'b1;
    dn_r_valid  = 1'b0;
    dn_r        = '0;
    up_r_ready  = 1'b1;
    isolate_req = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    check_bit("isolate_done", isolate_done, 1'b0);
    check_bit("dn_ar_valid", dn_ar_valid, 1'b0);
    check_bit("up_r_valid", up_r_valid, 1'b0);
    check_count("count_q", i_dut.u_tracker.count_q, '0);
    pass_through();
    back_pressure();
    outstanding_limit();
    isolation();
    release_and_drain();
    $display("errors: mismatches=%0d other=%0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    repeat (2 * BUDGET) @(posedge clk);
    $display("timeout: watchdog expired after %0d cycles", 2 * BUDGET);
    $display("Test failures found");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
axi_iso_axi_pkg.sv
axi_iso_ctrl_pkg.sv
axi_iso_skid.sv
axi_iso_req_tracker.sv
axi_iso_top.sv
axi_iso_props.sv
axi_iso_tb.sv

/* Makefile */
# Verilator build and run for the AXI read isolation testbench
VERILATOR ?= verilator
TOP       ?= axi_iso_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) axi_iso_macros.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
